// File: common/rename_defs.svh
// Sizing and opcode macros for the rename core, included by the RTL and the testbench
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

////////////////////////////////////////////////////////////
// Register and buffer sizes
////////////////////////////////////////////////////////////

// Architectural register count, RV32 integer file
`define ARCH_REGS 32

// Physical register count, twice the architectural file
`define PHYS_REGS 64

// Reorder buffer entries, must stay a power of two
`define ROB_DEPTH 8

////////////////////////////////////////////////////////////
// Opcodes of the register-writing formats
////////////////////////////////////////////////////////////

`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LOAD   7'b0000011

`endif

// File: common/rename_pkg.sv
// Shared index types and instruction layout for the rename core, referenced by scoped name
`include "rename_defs.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Index types
    ////////////////////////////////////////////////////////////

    // Architectural register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_idx_t;

    // Physical register number
    typedef logic [$clog2(`PHYS_REGS)-1:0] prf_idx_t;

    // Reorder buffer slot
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    ////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////

    // R-type field order
    // Register fields sit at the same bits in I, S and B formats,
    // so one view is enough for renaming
    typedef struct packed {
        logic [6:0] funct7;
        arch_idx_t  rs2;
        arch_idx_t  rs1;
        logic [2:0] funct3;
        arch_idx_t  rd;
        logic [6:0] opcode;
    } rv_inst_t;

endpackage

// File: common/rob_alloc_if.sv
// Allocation request from dispatch into the reorder buffer, with the tail slot returned
`timescale 1ns/1ns

interface rob_alloc_if;

    // Entry is written at the edge where alloc is high
    logic                 alloc;
    logic                 rd_wen;
    rename_pkg::arch_idx_t arch;
    rename_pkg::prf_idx_t new_prf;
    rename_pkg::prf_idx_t old_prf;

    // Returned by the ROB
    rename_pkg::rob_idx_t rob_idx;
    logic                 full;

    // Dispatch side
    modport dispatch (
        output alloc, rd_wen, arch, new_prf, old_prf,
        input  rob_idx, full
    );

    // ROB side
    modport rob (
        input  alloc, rd_wen, arch, new_prf, old_prf,
        output rob_idx, full
    );

endinterface

// File: common/commit_if.sv
// Commit of the ROB head, seen by the free list and the top level
`timescale 1ns/1ns

interface commit_if;

    // One-cycle pulse per committed entry, no back-pressure
    logic                  valid;
    logic                  rd_wen;
    rename_pkg::arch_idx_t arch;
    rename_pkg::prf_idx_t  new_prf;
    rename_pkg::prf_idx_t  old_prf;

    modport rob (output valid, rd_wen, arch, new_prf, old_prf);

    // Free list only reclaims the old mapping
    modport free_list (input valid, rd_wen, old_prf);

    modport top (input valid, rd_wen, arch, new_prf, old_prf);

endinterface

// File: design/dispatch_stage.sv
// Combinational dispatch decode, renaming sequence and ROB allocation for one instruction
`timescale 1ns/1ns
`include "rename_defs.svh"

module dispatch_stage (
    input  logic                  disp_valid_i,
    input  rename_pkg::rv_inst_t  disp_inst_i,
    output logic                  disp_ready_o,
    output rename_pkg::rob_idx_t  disp_rob_idx_o,
    output rename_pkg::prf_idx_t  disp_src1_prf_o,
    output rename_pkg::prf_idx_t  disp_src2_prf_o,
    output rename_pkg::prf_idx_t  disp_dest_prf_o,

    // Map table
    output rename_pkg::arch_idx_t map_src1_arch_o,
    output rename_pkg::arch_idx_t map_src2_arch_o,
    input  rename_pkg::prf_idx_t  map_src1_prf_i,
    input  rename_pkg::prf_idx_t  map_src2_prf_i,
    output logic                  map_write_o,
    output rename_pkg::arch_idx_t map_dest_arch_o,
    output rename_pkg::prf_idx_t  map_dest_prf_o,
    input  rename_pkg::prf_idx_t  map_old_prf_i,

    // Free list
    input  logic                  fl_empty_i,
    input  rename_pkg::prf_idx_t  fl_head_prf_i,
    output logic                  fl_pop_o,

    // ROB allocation
    rob_alloc_if.dispatch         alloc
);

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    logic rd_wen;
    logic writes_fmt;
    logic fire;

    // Only these formats produce a register result
    assign writes_fmt = (disp_inst_i.opcode == `OPC_OP)     ||
                        (disp_inst_i.opcode == `OPC_OP_IMM) ||
                        (disp_inst_i.opcode == `OPC_LOAD);

    // x0 writes are dropped
    assign rd_wen = writes_fmt && (disp_inst_i.rd != '0);

    // Stall on full ROB or no spare physical register
    assign disp_ready_o = !alloc.full && !fl_empty_i;
    assign fire         = disp_valid_i && disp_ready_o;

    ////////////////////////////////////////////////////////////
    // Source renaming
    ////////////////////////////////////////////////////////////

    // Both sources looked up always
    // rs2 may hold immediate bits, result then ignored downstream
    assign map_src1_arch_o = disp_inst_i.rs1;
    assign map_src2_arch_o = disp_inst_i.rs2;
    assign disp_src1_prf_o = map_src1_prf_i;
    assign disp_src2_prf_o = map_src2_prf_i;

    ////////////////////////////////////////////////////////////
    // Destination renaming
    ////////////////////////////////////////////////////////////

    // Free-list head becomes the new mapping of rd
    assign map_dest_arch_o = disp_inst_i.rd;
    assign map_dest_prf_o  = fl_head_prf_i;
    assign map_write_o     = fire && rd_wen;
    assign fl_pop_o        = fire && rd_wen;

    // Zero when nothing is written
    assign disp_dest_prf_o = rd_wen ? fl_head_prf_i : '0;

    ////////////////////////////////////////////////////////////
    // ROB entry
    ////////////////////////////////////////////////////////////

    assign alloc.alloc   = fire;
    assign alloc.rd_wen  = rd_wen;
    assign alloc.arch    = disp_inst_i.rd;
    assign alloc.new_prf = disp_dest_prf_o;
    // Current mapping of rd, freed at commit when rd_wen is set
    assign alloc.old_prf = map_old_prf_i;

    // Tail slot taken by this instruction
    assign disp_rob_idx_o = alloc.rob_idx;

endmodule

// File: design/map_table.sv
// Speculative architectural-to-physical register map with combinational lookup
`timescale 1ns/1ns
`include "rename_defs.svh"

module map_table (
    input  logic                  clock,
    input  logic                  reset,

    // Source lookups
    input  rename_pkg::arch_idx_t src1_arch_i,
    input  rename_pkg::arch_idx_t src2_arch_i,
    output rename_pkg::prf_idx_t  src1_prf_o,
    output rename_pkg::prf_idx_t  src2_prf_o,

    // Destination update
    input  logic                  write_i,
    input  rename_pkg::arch_idx_t dest_arch_i,
    input  rename_pkg::prf_idx_t  dest_prf_i,
    output rename_pkg::prf_idx_t  old_prf_o
);

    // One physical tag per architectural register
    rename_pkg::prf_idx_t map_q [`ARCH_REGS];

    // Reads see the value before this cycle's write
    assign src1_prf_o = map_q[src1_arch_i];
    assign src2_prf_o = map_q[src2_arch_i];
    assign old_prf_o  = map_q[dest_arch_i];

    ////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, x_i lives in p_i
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::prf_idx_t'(i);
            end
        end else if (write_i) begin
            map_q[dest_arch_i] <= dest_prf_i;
        end
    end

endmodule

// File: design/free_list.sv
// FIFO of unmapped physical registers, popped at dispatch and refilled at commit
`timescale 1ns/1ns
`include "rename_defs.svh"

module free_list (
    input  logic                 clock,
    input  logic                 reset,

    // Allocation
    input  logic                 pop_i,
    output rename_pkg::prf_idx_t head_prf_o,
    output logic                 empty_o,

    // Reclaim from commit
    commit_if.free_list          release_bus
);

    // Registers beyond the architectural set
    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    rename_pkg::prf_idx_t fl_q [FL_DEPTH];
    logic [PTR_W-1:0]     head_q;
    logic [PTR_W-1:0]     tail_q;
    logic [CNT_W-1:0]     count_q;
    logic                 push;

    // Old mapping only exists for writing instructions
    assign push = release_bus.valid && release_bus.rd_wen;

    assign head_prf_o = fl_q[head_q];
    assign empty_o    = (count_q == '0);

    ////////////////////////////////////////////////////////////
    // Queue state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Starts full with p32 upward
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_q[i] <= rename_pkg::prf_idx_t'(`ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(FL_DEPTH);
        end else begin
            if (push) begin
                fl_q[tail_q] <= release_bus.old_prf;
                tail_q       <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: rob/rob.sv
// Reorder buffer with out-of-order completion marking and in-order single commit
`timescale 1ns/1ns
`include "rename_defs.svh"

module rob (
    input  logic                 clock,
    input  logic                 reset,

    // Allocation from dispatch
    rob_alloc_if.rob             alloc,

    // Completion
    input  logic                 complete_valid_i,
    input  rename_pkg::rob_idx_t complete_rob_idx_i,

    // Head commit
    commit_if.rob                commit
);

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////////////////////////

    // Per-entry status bits
    logic [`ROB_DEPTH-1:0] occupied_q;
    logic [`ROB_DEPTH-1:0] done_q;

    // Per-entry payload
    logic                  rd_wen_q  [`ROB_DEPTH];
    rename_pkg::arch_idx_t arch_q    [`ROB_DEPTH];
    rename_pkg::prf_idx_t  new_prf_q [`ROB_DEPTH];
    rename_pkg::prf_idx_t  old_prf_q [`ROB_DEPTH];

    // Pointers and occupancy
    rename_pkg::rob_idx_t  head_q;
    rename_pkg::rob_idx_t  tail_q;
    logic [CNT_W-1:0]      count_q;
    logic                  pop;

    ////////////////////////////////////////////////////////////
    // Status outputs
    ////////////////////////////////////////////////////////////

    assign alloc.full    = (count_q == CNT_W'(`ROB_DEPTH));
    assign alloc.rob_idx = tail_q;

    // Head retires once it is both allocated and finished
    assign pop = occupied_q[head_q] && done_q[head_q];

    assign commit.valid   = pop;
    assign commit.rd_wen  = rd_wen_q[head_q];
    assign commit.arch    = arch_q[head_q];
    assign commit.new_prf = new_prf_q[head_q];
    assign commit.old_prf = old_prf_q[head_q];

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied_q <= '0;
            done_q     <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
        end else begin
            // Free the head slot
            if (pop) begin
                occupied_q[head_q] <= 1'b0;
                done_q[head_q]     <= 1'b0;
                head_q             <= head_q + 1'b1;
            end
            // Open a new slot at the tail
            if (alloc.alloc) begin
                occupied_q[tail_q] <= 1'b1;
                done_q[tail_q]     <= 1'b0;
                tail_q             <= tail_q + 1'b1;
            end
            // Completions may arrive in any order
            if (complete_valid_i && occupied_q[complete_rob_idx_i]) begin
                done_q[complete_rob_idx_i] <= 1'b1;
            end
            case ({alloc.alloc, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload written on allocation only
    always_ff @(posedge clock) begin
        if (alloc.alloc) begin
            rd_wen_q[tail_q]  <= alloc.rd_wen;
            arch_q[tail_q]    <= alloc.arch;
            new_prf_q[tail_q] <= alloc.new_prf;
            old_prf_q[tail_q] <= alloc.old_prf;
        end
    end

endmodule

// File: design/rename_core.sv
// Top level of the rename core, joins dispatch, map table, free list and ROB
`timescale 1ns/1ns

module rename_core (
    input  logic                  clock,
    input  logic                  reset,

    // Dispatch
    input  logic                  disp_valid_i,
    input  rename_pkg::rv_inst_t  disp_inst_i,
    output logic                  disp_ready_o,
    output rename_pkg::rob_idx_t  disp_rob_idx_o,
    output rename_pkg::prf_idx_t  disp_src1_prf_o,
    output rename_pkg::prf_idx_t  disp_src2_prf_o,
    output rename_pkg::prf_idx_t  disp_dest_prf_o,

    // Completion
    input  logic                  complete_valid_i,
    input  rename_pkg::rob_idx_t  complete_rob_idx_i,

    // Commit
    output logic                  commit_valid_o,
    output rename_pkg::arch_idx_t commit_arch_o,
    output rename_pkg::prf_idx_t  commit_new_prf_o,
    output rename_pkg::prf_idx_t  commit_old_prf_o,
    output logic                  commit_rd_wen_o
);

    ////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////

    // Map table lookups and update
    rename_pkg::arch_idx_t src1_arch;
    rename_pkg::arch_idx_t src2_arch;
    rename_pkg::prf_idx_t  src1_prf;
    rename_pkg::prf_idx_t  src2_prf;
    logic                  map_write;
    rename_pkg::arch_idx_t dest_arch;
    rename_pkg::prf_idx_t  dest_prf;
    rename_pkg::prf_idx_t  old_prf;

    // Free list allocation
    logic                  fl_empty;
    rename_pkg::prf_idx_t  fl_head_prf;
    logic                  fl_pop;

    rob_alloc_if alloc_bus ();
    commit_if    commit_bus ();

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    dispatch_stage dispatch_i (
        .disp_valid_i    (disp_valid_i),
        .disp_inst_i     (disp_inst_i),
        .disp_ready_o    (disp_ready_o),
        .disp_rob_idx_o  (disp_rob_idx_o),
        .disp_src1_prf_o (disp_src1_prf_o),
        .disp_src2_prf_o (disp_src2_prf_o),
        .disp_dest_prf_o (disp_dest_prf_o),
        .map_src1_arch_o (src1_arch),
        .map_src2_arch_o (src2_arch),
        .map_src1_prf_i  (src1_prf),
        .map_src2_prf_i  (src2_prf),
        .map_write_o     (map_write),
        .map_dest_arch_o (dest_arch),
        .map_dest_prf_o  (dest_prf),
        .map_old_prf_i   (old_prf),
        .fl_empty_i      (fl_empty),
        .fl_head_prf_i   (fl_head_prf),
        .fl_pop_o        (fl_pop),
        .alloc           (alloc_bus.dispatch)
    );

    map_table map_table_i (
        .clock       (clock),
        .reset       (reset),
        .src1_arch_i (src1_arch),
        .src2_arch_i (src2_arch),
        .src1_prf_o  (src1_prf),
        .src2_prf_o  (src2_prf),
        .write_i     (map_write),
        .dest_arch_i (dest_arch),
        .dest_prf_i  (dest_prf),
        .old_prf_o   (old_prf)
    );

    free_list free_list_i (
        .clock       (clock),
        .reset       (reset),
        .pop_i       (fl_pop),
        .head_prf_o  (fl_head_prf),
        .empty_o     (fl_empty),
        .release_bus (commit_bus.free_list)
    );

    rob rob_i (
        .clock              (clock),
        .reset              (reset),
        .alloc              (alloc_bus.rob),
        .complete_valid_i   (complete_valid_i),
        .complete_rob_idx_i (complete_rob_idx_i),
        .commit             (commit_bus.rob)
    );

    // Commit report straight from the ROB head
    assign commit_valid_o   = commit_bus.valid;
    assign commit_arch_o    = commit_bus.arch;
    assign commit_new_prf_o = commit_bus.new_prf;
    assign commit_old_prf_o = commit_bus.old_prf;
    assign commit_rd_wen_o  = commit_bus.rd_wen;

endmodule

// File: dv/rename_core_tb.sv
// Self-checking testbench for rename_core, runs a table of instructions against a reference model
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_core_tb;

    localparam int rows_n      = 44;
    localparam int cycle_limit = rows_n * 30;
    localparam logic [6:0] store_opc  = 7'b0100011;
    localparam logic [6:0] branch_opc = 7'b1100011;

    logic                  clock;
    logic                  reset;
    logic                  disp_valid_i;
    rename_pkg::rv_inst_t  disp_inst_i;
    logic                  disp_ready_o;
    rename_pkg::rob_idx_t  disp_rob_idx_o;
    rename_pkg::prf_idx_t  disp_src1_prf_o;
    rename_pkg::prf_idx_t  disp_src2_prf_o;
    rename_pkg::prf_idx_t  disp_dest_prf_o;
    logic                  complete_valid_i;
    rename_pkg::rob_idx_t  complete_rob_idx_i;
    logic                  commit_valid_o;
    rename_pkg::arch_idx_t commit_arch_o;
    rename_pkg::prf_idx_t  commit_new_prf_o;
    rename_pkg::prf_idx_t  commit_old_prf_o;
    logic                  commit_rd_wen_o;

    // Stimulus table, one instruction and one completion delay per row
    rename_pkg::rv_inst_t  inst_tab [rows_n];
    int                    delay_tab [rows_n];

    // Reference model state
    rename_pkg::prf_idx_t  map_m [`ARCH_REGS];
    rename_pkg::prf_idx_t  fl_m [$];
    rename_pkg::rob_idx_t  rob_tail_m;
    int                    rob_count_m;

    // Slots whose completion has reached the ROB
    logic                  done_m [`ROB_DEPTH];

    // Expected commits, oldest first
    logic                  exp_wen_q [$];
    rename_pkg::arch_idx_t exp_arch_q [$];
    rename_pkg::prf_idx_t  exp_new_q [$];
    rename_pkg::prf_idx_t  exp_old_q [$];
    int                    exp_row_q [$];

    // Completion scheduling per ROB slot
    logic                  pending [`ROB_DEPTH];
    int                    due [`ROB_DEPTH];
    int                    row_of [`ROB_DEPTH];
    logic                  hold_complete;

    int next_row = 0;
    int cycles   = 0;
    int checks   = 0;
    int errors   = 0;
    int commits  = 0;
    int seed     = 32'h058c_e487;

    rename_core dut_i (
        .clock              (clock),
        .reset              (reset),
        .disp_valid_i       (disp_valid_i),
        .disp_inst_i        (disp_inst_i),
        .disp_ready_o       (disp_ready_o),
        .disp_rob_idx_o     (disp_rob_idx_o),
        .disp_src1_prf_o    (disp_src1_prf_o),
        .disp_src2_prf_o    (disp_src2_prf_o),
        .disp_dest_prf_o    (disp_dest_prf_o),
        .complete_valid_i   (complete_valid_i),
        .complete_rob_idx_i (complete_rob_idx_i),
        .commit_valid_o     (commit_valid_o),
        .commit_arch_o      (commit_arch_o),
        .commit_new_prf_o   (commit_new_prf_o),
        .commit_old_prf_o   (commit_old_prf_o),
        .commit_rd_wen_o    (commit_rd_wen_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Watchdog
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles <= cycles + 1;
        end
        $display("ERROR the run did not finish in time, stopped after %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_prf(input string name, input rename_pkg::prf_idx_t expected,
                             input rename_pkg::prf_idx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_rob_idx(input string name, input rename_pkg::rob_idx_t expected,
                                 input rename_pkg::rob_idx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_arch(input string name, input rename_pkg::arch_idx_t expected,
                              input rename_pkg::arch_idx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // OP, OP_IMM and LOAD write rd, except x0
    function automatic logic writes_register(input rename_pkg::rv_inst_t inst);
        logic fmt;
        fmt = (inst.opcode == `OPC_OP) || (inst.opcode == `OPC_OP_IMM) ||
              (inst.opcode == `OPC_LOAD);
        return fmt && (inst.rd != 5'd0);
    endfunction

    ////////////////////////////////////////////////////////////
    // Monitor at the falling edge, inputs and outputs settled
    ////////////////////////////////////////////////////////////

    task automatic observe();
        logic                 wen;
        logic                 release_now;
        rename_pkg::prf_idx_t release_prf;
        rename_pkg::prf_idx_t exp_dest;
        rename_pkg::rob_idx_t head;
        int                   row;
        release_now = 1'b0;
        release_prf = '0;
        check_bit("ready", (rob_count_m < `ROB_DEPTH) && (fl_m.size() > 0), disp_ready_o);
        // Oldest in-flight slot, commits once its completion has landed
        head = rob_tail_m - rename_pkg::rob_idx_t'(rob_count_m);
        check_bit("commit valid", (rob_count_m > 0) && done_m[head], commit_valid_o);
        // Commit first, its freed register joins the queue after this cycle's pop
        if (commit_valid_o) begin
            if (exp_wen_q.size() == 0) begin
                errors++;
                $display("ERROR a commit was reported with no instruction in flight");
            end else begin
                row = exp_row_q.pop_front();
                check_bit($sformatf("row %0d commit rd_wen", row), exp_wen_q[0], commit_rd_wen_o);
                check_arch($sformatf("row %0d commit arch", row), exp_arch_q[0], commit_arch_o);
                check_prf($sformatf("row %0d commit new", row), exp_new_q[0], commit_new_prf_o);
                check_prf($sformatf("row %0d commit old", row), exp_old_q[0], commit_old_prf_o);
                release_now = exp_wen_q[0];
                release_prf = exp_old_q[0];
                void'(exp_wen_q.pop_front());
                void'(exp_arch_q.pop_front());
                void'(exp_new_q.pop_front());
                void'(exp_old_q.pop_front());
                done_m[head] = 1'b0;
                rob_count_m--;
                commits++;
            end
        end
        if (disp_valid_i && disp_ready_o) begin
            wen = writes_register(disp_inst_i);
            // Register reuse follows from the FIFO order of the model queue
            exp_dest = wen ? fl_m.pop_front() : '0;
            check_rob_idx($sformatf("row %0d rob_idx", next_row), rob_tail_m, disp_rob_idx_o);
            check_prf($sformatf("row %0d src1", next_row), map_m[disp_inst_i.rs1], disp_src1_prf_o);
            check_prf($sformatf("row %0d src2", next_row), map_m[disp_inst_i.rs2], disp_src2_prf_o);
            check_prf($sformatf("row %0d dest", next_row), exp_dest, disp_dest_prf_o);
            exp_wen_q.push_back(wen);
            exp_arch_q.push_back(disp_inst_i.rd);
            exp_new_q.push_back(exp_dest);
            exp_old_q.push_back(map_m[disp_inst_i.rd]);
            exp_row_q.push_back(next_row);
            if (wen) begin
                map_m[disp_inst_i.rd] = exp_dest;
            end
            row_of[rob_tail_m]  = next_row;
            pending[rob_tail_m] = 1'b1;
            due[rob_tail_m]     = cycles + delay_tab[next_row];
            rob_tail_m          = rob_tail_m + 3'd1;
            rob_count_m++;
            next_row++;
        end
        if (release_now) begin
            fl_m.push_back(release_prf);
        end
        // Completion presented now lands at the coming edge
        if (complete_valid_i) begin
            done_m[complete_rob_idx_i] = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Driver at the rising edge
    ////////////////////////////////////////////////////////////

    task automatic drive();
        int pick;
        pick = -1;
        disp_valid_i <= (next_row < rows_n);
        disp_inst_i  <= inst_tab[(next_row < rows_n) ? next_row : rows_n - 1];
        // Earliest expired slot, order differs from dispatch order
        if (!hold_complete) begin
            for (int k = 0; k < `ROB_DEPTH; k++) begin
                if (pending[k] && (due[k] <= cycles) && ((pick < 0) || (due[k] < due[pick]))) begin
                    pick = k;
                end
            end
        end
        if (pick >= 0) begin
            pending[pick] = 1'b0;
            complete_valid_i   <= 1'b1;
            complete_rob_idx_i <= rename_pkg::rob_idx_t'(pick);
        end else begin
            complete_valid_i <= 1'b0;
        end
    endtask

    task automatic run_cycle();
        @(negedge clock);
        observe();
        @(posedge clock);
        drive();
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rename_pkg::rv_inst_t inst;
        int                   base;
        reset              = 1'b1;
        disp_valid_i       = 1'b0;
        disp_inst_i        = '0;
        complete_valid_i   = 1'b0;
        complete_rob_idx_i = '0;
        hold_complete      = 1'b1;
        rob_tail_m         = '0;
        rob_count_m        = 0;
        // Mix of writers, stores, branches and x0 writes
        for (int i = 0; i < rows_n; i++) begin
            inst.funct7 = 7'(i);
            inst.rs2    = rename_pkg::arch_idx_t'((i * 5 + 1) % 32);
            inst.rs1    = rename_pkg::arch_idx_t'((i * 3) % 32);
            inst.funct3 = 3'(i % 8);
            inst.rd     = rename_pkg::arch_idx_t'(1 + (i * 7) % 31);
            case (i % 8)
                0, 3:    inst.opcode = `OPC_OP;
                1, 4:    inst.opcode = `OPC_OP_IMM;
                2, 5:    inst.opcode = `OPC_LOAD;
                6:       inst.opcode = store_opc;
                default: begin
                    inst.opcode = (i % 16 == 7) ? branch_opc : `OPC_OP;
                    if (i % 16 != 7) begin
                        inst.rd = '0;
                    end
                end
            endcase
            inst_tab[i]  = inst;
            delay_tab[i] = 1 + ($unsigned($random(seed)) % 12);
        end
        // Model starts like the reset state
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = rename_pkg::prf_idx_t'(i);
        end
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            fl_m.push_back(rename_pkg::prf_idx_t'(i));
        end
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            pending[k] = 1'b0;
            done_m[k]  = 1'b0;
            due[k]     = 0;
            row_of[k]  = 0;
        end

        repeat (4) @(posedge clock);
        reset <= 1'b0;

        base = errors;
        @(negedge clock);
        check_bit("reset ready", 1'b1, disp_ready_o);
        check_bit("reset commit_valid", 1'b0, commit_valid_o);
        report_test("reset", base);

        // Fill the ROB with nothing completed
        base = errors;
        @(posedge clock);
        drive();
        while (rob_count_m < `ROB_DEPTH) begin
            run_cycle();
        end
        // Tail stays put while the offered strobe is refused
        repeat (2) begin
            @(negedge clock);
            check_bit("full ready", 1'b0, disp_ready_o);
            check_rob_idx("full rob_idx", rob_tail_m, disp_rob_idx_o);
            observe();
            @(posedge clock);
            drive();
        end
        // Delays count from the release
        hold_complete = 1'b0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            if (pending[k]) begin
                due[k] = cycles + delay_tab[row_of[k]];
            end
        end
        while (commits == 0) begin
            run_cycle();
        end
        @(negedge clock);
        check_bit("ready after commit", 1'b1, disp_ready_o);
        observe();
        @(posedge clock);
        drive();
        report_test("backpressure", base);

        // Remaining rows, completion out of order, drain to empty
        base = errors;
        while ((next_row < rows_n) || (exp_wen_q.size() > 0)) begin
            run_cycle();
        end
        report_test("rename_commit", base);

        $display("tests 3, checks %0d, errors %0d, commits %0d", checks, errors, commits);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/rename_pkg.sv
common/rob_alloc_if.sv
common/commit_if.sv
design/dispatch_stage.sv
design/map_table.sv
design/free_list.sv
rob/rob.sv
design/rename_core.sv
dv/rename_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := rename_core_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
